// File: hdl/dx_cfg.svh
// width and option macros for the decode to execute stage
// delay slot and pipelined multiplier selection

`ifndef DX_CFG_SVH
`define DX_CFG_SVH

// data path and pc width
`define DX_OPERAND_W 32

// register file address width
`define DX_RF_ADDR_W 5

// short immediate and upper jump immediate
`define DX_IMM16_W 16
`define DX_IMMJBR_W 10

// alu sub-opcode width
`define DX_ALU_OPC_W 4

// 1: branches have a delay slot, link address is pc + 8
`define DX_DELAY_SLOT 1

// 1: multiply result arrives in control stage
`define DX_MUL_PIPELINED 1

`endif

// File: hdl/dx_pkg.sv
// opcode enum and packed instruction structs for the decode to execute stage
// also the control stage hazard descriptor

`include "dx_cfg.svh"

package dx_pkg;

   // instruction class, decoded further downstream
   typedef enum logic [3:0] {
      OPC_NOP          = 4'd0,
      OPC_ALU          = 4'd1,
      OPC_LOAD         = 4'd2,
      OPC_STORE        = 4'd3,
      OPC_ATOMIC_STORE = 4'd4,
      OPC_MFSPR        = 4'd5,
      OPC_MTSPR        = 4'd6,
      OPC_MUL          = 4'd7,
      OPC_J            = 4'd8,
      OPC_JAL          = 4'd9,
      OPC_BF           = 4'd10,
      OPC_BNF          = 4'd11,
      OPC_JR           = 4'd12,
      OPC_JALR         = 4'd13,
      OPC_RFE          = 4'd14
   } opc_e;

   typedef struct packed {
      opc_e                       opc;
      logic [`DX_OPERAND_W-1:0]   pc;
      logic [`DX_RF_ADDR_W-1:0]   rfa;
      logic [`DX_RF_ADDR_W-1:0]   rfb;
      logic [`DX_RF_ADDR_W-1:0]   rfd;
      logic                       rf_wb;
      logic [`DX_IMM16_W-1:0]     imm16;
      logic [`DX_IMMJBR_W-1:0]    immjbr_upper;
      logic [`DX_OPERAND_W-1:0]   immediate;
      logic                       imm_sel;
      logic [`DX_ALU_OPC_W-1:0]   alu_opc;
      logic [1:0]                 lsu_len;
      logic                       lsu_zext;
      logic                       adder_sub;
      logic                       adder_carry;
      // exceptions raised in fetch and decode
      logic                       ibus_err;
      logic                       itlb_miss;
      logic                       ipagefault;
      logic                       illegal;
      logic                       syscall;
      logic                       trap;
   } dec_insn_t;

   typedef struct packed {
      dec_insn_t                  insn;
      logic                       except_align;
      logic [`DX_OPERAND_W-1:0]   jal_result;
      logic                       predicted_flag;
      logic [`DX_OPERAND_W-1:0]   mispredict_target;
   } exe_insn_t;

   // what the control stage instruction will write late
   typedef struct packed {
      logic [`DX_RF_ADDR_W-1:0]   rfd;
      logic                       is_load;
      logic                       is_mfspr;
      logic                       is_mul;
   } ctrl_hazard_t;

endpackage

// File: hdl/dx_hazard.sv
// hazard detection between decode, execute and control stages
// produces the decode bubble and the jump-register stall

`timescale 1ns/1ps

`include "dx_cfg.svh"

module dx_hazard
   import dx_pkg::*;
(
   input  dec_insn_t    dec_i,
   input  exe_insn_t    exe_i,
   input  ctrl_hazard_t ctrl_i,
   input  logic         padv_i,
   output logic         decode_bubble_o,
   output logic         jr_stall_o
);

   localparam bit MUL_PIPE = (`DX_MUL_PIPELINED != 0);

   logic ctrl_late;
   logic ctrl_interlock;
   logic exe_ab_hit;
   logic exe_b_hit;
   logic exe_late;
   logic load_use;
   logic mul_use;
   logic atomic_wait;
   logic rfe_wait;

   // control stage result not yet available for bypass
   assign ctrl_late = ctrl_i.is_load | ctrl_i.is_mfspr | (ctrl_i.is_mul & MUL_PIPE);
   assign ctrl_interlock = ctrl_late &
                           ((dec_i.rfa == ctrl_i.rfd) || (dec_i.rfb == ctrl_i.rfd));

   assign exe_ab_hit = (dec_i.rfa == exe_i.insn.rfd) || (dec_i.rfb == exe_i.insn.rfd);
   assign exe_b_hit  = (dec_i.rfb == exe_i.insn.rfd);

   // execute stage ops whose result only appears in control
   assign exe_late = (exe_i.insn.opc == OPC_LOAD) ||
                     (exe_i.insn.opc == OPC_MFSPR) ||
                     ((exe_i.insn.opc == OPC_MUL) && MUL_PIPE);

   assign load_use = exe_late & exe_ab_hit;

   // a pipelined multiply needs both operands at the start of execute
   assign mul_use = MUL_PIPE && (dec_i.opc == OPC_MUL) &&
                    (ctrl_interlock || (exe_i.insn.rf_wb && exe_ab_hit));

   // jump target register still being produced
   assign jr_stall_o = ((dec_i.opc == OPC_JR) || (dec_i.opc == OPC_JALR)) &&
                       (ctrl_interlock || (exe_i.insn.rf_wb && exe_b_hit));

   assign atomic_wait = (exe_i.insn.opc == OPC_ATOMIC_STORE);

   // hold fetch while rfe travels to the control stage
   assign rfe_wait = (dec_i.opc == OPC_RFE);

   assign decode_bubble_o = padv_i &
                            (load_use | mul_use | jr_stall_o | atomic_wait | rfe_wait);

endmodule

// File: hdl/dx_branch.sv
// branch resolution in decode
// immediate and register targets, link value, mispredict target
// and the misaligned target exception

`timescale 1ns/1ps

`include "dx_cfg.svh"

module dx_branch
   import dx_pkg::*;
(
   input  dec_insn_t                dec_i,
   input  opc_e                     exe_opc_i,
   input  logic                     execute_bubble_i,
   input  logic                     predicted_flag_i,
   input  logic                     jr_stall_i,
   input  logic                     flush_i,
   input  logic [`DX_OPERAND_W-1:0] decode_rfb_i,
   input  logic [`DX_OPERAND_W-1:0] execute_rfb_i,
   output logic                     branch_o,
   output logic [`DX_OPERAND_W-1:0] target_o,
   output logic [`DX_OPERAND_W-1:0] jal_result_o,
   output logic [`DX_OPERAND_W-1:0] mispredict_target_o,
   output logic                     except_align_o
);

   // sign bits above the word-aligned jump offset
   localparam int EXT_W = `DX_OPERAND_W - `DX_IMMJBR_W - `DX_IMM16_W - 2;
   localparam int unsigned NEXT_PC_STEP = (`DX_DELAY_SLOT != 0) ? 8 : 4;

   logic                     is_bf;
   logic                     is_bnf;
   logic                     dec_is_jr;
   logic                     exe_is_jr;
   logic                     branch_to_imm;
   logic                     branch_to_reg;
   logic [`DX_OPERAND_W-1:0] imm_offset;
   logic [`DX_OPERAND_W-1:0] imm_target;
   logic [`DX_OPERAND_W-1:0] reg_target;
   logic [`DX_OPERAND_W-1:0] next_pc;

   assign is_bf     = (dec_i.opc == OPC_BF);
   assign is_bnf    = (dec_i.opc == OPC_BNF);
   assign dec_is_jr = (dec_i.opc == OPC_JR) || (dec_i.opc == OPC_JALR);
   assign exe_is_jr = (exe_opc_i == OPC_JR) || (exe_opc_i == OPC_JALR);

   // unconditional jumps, or conditional ones predicted taken
   assign branch_to_imm = (dec_i.opc == OPC_J) || (dec_i.opc == OPC_JAL) ||
                          (is_bf && predicted_flag_i) ||
                          (is_bnf && !predicted_flag_i);

   // register jumps wait until the target register is ready
   assign branch_to_reg = dec_is_jr && !jr_stall_i;

   assign imm_offset = {{EXT_W{dec_i.immjbr_upper[`DX_IMMJBR_W-1]}},
                        dec_i.immjbr_upper, dec_i.imm16, 2'b00};
   assign imm_target = dec_i.pc + imm_offset;

   // after a bubble the producer of rfb has moved on to execute,
   // so the operand must come from the execute side
   assign reg_target = (execute_bubble_i || exe_is_jr) ? execute_rfb_i : decode_rfb_i;

   assign branch_o = (branch_to_imm || branch_to_reg) && !flush_i;
   assign target_o = branch_to_imm ? imm_target : reg_target;

   assign except_align_o = branch_o && (target_o[1:0] != 2'b00);

   assign next_pc      = dec_i.pc + `DX_OPERAND_W'(NEXT_PC_STEP);
   assign jal_result_o = next_pc;

   // recovery pc if the prediction turns out wrong
   assign mispredict_target_o = ((is_bf && !predicted_flag_i) ||
                                 (is_bnf && predicted_flag_i)) ? imm_target : next_pc;

endmodule

// File: hdl/dx_stage_reg.sv
// execute stage pipeline register
// control fields with reset, flush and bubble handling, data fields without reset
// checks on flush and valid behaviour

`timescale 1ns/1ps

`include "dx_cfg.svh"

module dx_stage_reg
   import dx_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     padv_i,
   input  logic                     flush_i,
   input  logic                     bubble_i,
   input  dec_insn_t                dec_i,
   input  logic                     except_align_i,
   input  logic [`DX_OPERAND_W-1:0] jal_result_i,
   input  logic [`DX_OPERAND_W-1:0] mispredict_target_i,
   input  logic                     predicted_flag_i,
   output exe_insn_t                exe_o,
   output logic                     execute_bubble_o,
   output logic                     decode_valid_o
);

   dec_insn_t                insn_q;
   logic [`DX_OPERAND_W-1:0] jal_result_q;
   logic [`DX_OPERAND_W-1:0] mispredict_target_q;
   logic                     predicted_flag_q;
   opc_e                     opc_q;
   logic                     rf_wb_q;
   logic                     adder_sub_q;
   logic                     adder_carry_q;
   logic [5:0]               except_q;
   logic                     except_align_q;

   // payload, just follows the pipeline advance
   always_ff @(posedge clk) begin
      if (padv_i) begin
         insn_q       <= dec_i;
         jal_result_q <= jal_result_i;
      end
   end

   // prediction info only matters for conditional branches
   always_ff @(posedge clk) begin
      if (padv_i && ((dec_i.opc == OPC_BF) || (dec_i.opc == OPC_BNF))) begin
         predicted_flag_q    <= predicted_flag_i;
         mispredict_target_q <= mispredict_target_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst || flush_i) begin
         opc_q            <= OPC_NOP;
         rf_wb_q          <= 1'b0;
         adder_sub_q      <= 1'b0;
         adder_carry_q    <= 1'b0;
         execute_bubble_o <= 1'b0;
      end else if (padv_i) begin
         execute_bubble_o <= bubble_i;
         if (bubble_i) begin
            // rfe keeps filling the pipe until its own flush clears it
            opc_q         <= (dec_i.opc == OPC_RFE) ? OPC_RFE : OPC_NOP;
            rf_wb_q       <= 1'b0;
            adder_sub_q   <= 1'b0;
            adder_carry_q <= 1'b0;
         end else begin
            opc_q         <= dec_i.opc;
            rf_wb_q       <= dec_i.rf_wb;
            adder_sub_q   <= dec_i.adder_sub;
            adder_carry_q <= dec_i.adder_carry;
         end
      end
   end

   // exceptions are not dropped by flush
   always_ff @(posedge clk) begin
      if (rst) begin
         except_q       <= '0;
         except_align_q <= 1'b0;
      end else if (padv_i) begin
         except_q       <= {dec_i.ibus_err, dec_i.itlb_miss, dec_i.ipagefault,
                            dec_i.illegal, dec_i.syscall, dec_i.trap};
         except_align_q <= except_align_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         decode_valid_o <= 1'b0;
      end else begin
         decode_valid_o <= padv_i;
      end
   end

   always_comb begin
      exe_o                   = '{insn: insn_q, except_align: except_align_q,
                                  jal_result: jal_result_q,
                                  predicted_flag: predicted_flag_q,
                                  mispredict_target: mispredict_target_q};
      exe_o.insn.opc          = opc_q;
      exe_o.insn.rf_wb        = rf_wb_q;
      exe_o.insn.adder_sub    = adder_sub_q;
      exe_o.insn.adder_carry  = adder_carry_q;
      exe_o.insn.ibus_err     = except_q[5];
      exe_o.insn.itlb_miss    = except_q[4];
      exe_o.insn.ipagefault   = except_q[3];
      exe_o.insn.illegal      = except_q[2];
      exe_o.insn.syscall      = except_q[1];
      exe_o.insn.trap         = except_q[0];
   end

   // a flushed stage holds nothing that writes back
   a_flush_nop : assert property (@(posedge clk) disable iff (rst)
      flush_i |=> (exe_o.insn.opc == OPC_NOP) && !exe_o.insn.rf_wb);

   a_valid_follows_padv : assert property (@(posedge clk) disable iff (rst)
      1'b1 |=> (decode_valid_o == $past(padv_i)));

endmodule

// File: hdl/decode_execute.sv
// decode to execute stage top level
// hazard detection, branch resolution and the execute pipeline register

`timescale 1ns/1ps

`include "dx_cfg.svh"

module decode_execute
   import dx_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst,
   input  dec_insn_t                dec_i,
   input  ctrl_hazard_t             ctrl_i,
   input  logic [`DX_OPERAND_W-1:0] decode_rfb_i,
   input  logic [`DX_OPERAND_W-1:0] execute_rfb_i,
   input  logic                     predicted_flag_i,
   input  logic                     padv_i,
   input  logic                     pipeline_flush_i,
   output exe_insn_t                exe_o,
   output logic                     execute_bubble_o,
   output logic                     decode_bubble_o,
   output logic                     decode_valid_o,
   output logic                     decode_branch_o,
   output logic [`DX_OPERAND_W-1:0] decode_branch_target_o
);

   logic                     jr_stall;
   logic                     except_align;
   logic [`DX_OPERAND_W-1:0] jal_result;
   logic [`DX_OPERAND_W-1:0] mispredict_target;

   dx_hazard u_hazard (
      .dec_i           (dec_i),
      .exe_i           (exe_o),
      .ctrl_i          (ctrl_i),
      .padv_i          (padv_i),
      .decode_bubble_o (decode_bubble_o),
      .jr_stall_o      (jr_stall)
   );

   dx_branch u_branch (
      .dec_i               (dec_i),
      .exe_opc_i           (exe_o.insn.opc),
      .execute_bubble_i    (execute_bubble_o),
      .predicted_flag_i    (predicted_flag_i),
      .jr_stall_i          (jr_stall),
      .flush_i             (pipeline_flush_i),
      .decode_rfb_i        (decode_rfb_i),
      .execute_rfb_i       (execute_rfb_i),
      .branch_o            (decode_branch_o),
      .target_o            (decode_branch_target_o),
      .jal_result_o        (jal_result),
      .mispredict_target_o (mispredict_target),
      .except_align_o      (except_align)
   );

   dx_stage_reg u_stage_reg (
      .clk                 (clk),
      .rst                 (rst),
      .padv_i              (padv_i),
      .flush_i             (pipeline_flush_i),
      .bubble_i            (decode_bubble_o),
      .dec_i               (dec_i),
      .except_align_i      (except_align),
      .jal_result_i        (jal_result),
      .mispredict_target_i (mispredict_target),
      .predicted_flag_i    (predicted_flag_i),
      .exe_o               (exe_o),
      .execute_bubble_o    (execute_bubble_o),
      .decode_valid_o      (decode_valid_o)
   );

endmodule

// File: sim/tb_decode_execute.sv
// testbench for the decode to execute stage
// xorshift stimulus, reference model of the hazard, branch and register rules

`timescale 1ns/1ps

`include "dx_cfg.svh"

module tb_decode_execute
   import dx_pkg::*;
();

   localparam int NUM_CYCLES     = 3000;
   localparam int TIMEOUT_CYCLES = NUM_CYCLES + 1000;
   localparam int OPW            = `DX_OPERAND_W;
   localparam int OFF_W          = `DX_IMMJBR_W + `DX_IMM16_W + 2;

   logic           clk;
   logic           rst;
   dec_insn_t      dec_i;
   ctrl_hazard_t   ctrl_i;
   logic [OPW-1:0] decode_rfb_i;
   logic [OPW-1:0] execute_rfb_i;
   logic           predicted_flag_i;
   logic           padv_i;
   logic           pipeline_flush_i;
   exe_insn_t      exe_o;
   logic           execute_bubble_o;
   logic           decode_bubble_o;
   logic           decode_valid_o;
   logic           decode_branch_o;
   logic [OPW-1:0] decode_branch_target_o;

   // model of the execute stage, current and after the next edge
   exe_insn_t      m_exe;
   exe_insn_t      nxt_exe;
   logic           m_bub;
   logic           nxt_bub;
   logic           m_valid;
   logic           nxt_valid;
   bit             data_known;
   bit             nxt_data_known;
   bit             pred_known;
   bit             nxt_pred_known;

   logic           exp_bubble;
   logic           exp_branch;
   logic           exp_align;
   logic           check_target;
   logic [OPW-1:0] exp_target;
   logic [OPW-1:0] exp_next_pc;
   logic [OPW-1:0] exp_mispredict;

   logic [31:0]    rng_state;
   int             errors;
   int             checks;
   int             cycle_cnt;

   decode_execute DUT (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // mostly a few low registers so that addresses collide
   function automatic logic [`DX_RF_ADDR_W-1:0] pick_reg();
      logic [31:0] r;
      r = next_rand();
      if (r[1:0] != 2'b00) begin
         return `DX_RF_ADDR_W'(r[3:2]);
      end
      return r[8:4];
   endfunction

   function automatic exe_insn_t make_inert(input exe_insn_t x, input opc_e op);
      exe_insn_t y;
      y = x;
      y.insn.opc = op;
      y.insn.rf_wb = 1'b0;
      y.insn.adder_sub = 1'b0;
      y.insn.adder_carry = 1'b0;
      return y;
   endfunction

   // data fields hold no value until the first capture
   function automatic exe_insn_t mask_unknown(input exe_insn_t x, input bit dk, input bit pk);
      exe_insn_t y;
      y = x;
      if (!dk) begin
         y.insn.pc = '0;
         y.insn.rfa = '0;
         y.insn.rfb = '0;
         y.insn.rfd = '0;
         y.insn.imm16 = '0;
         y.insn.immjbr_upper = '0;
         y.insn.immediate = '0;
         y.insn.imm_sel = 1'b0;
         y.insn.alu_opc = '0;
         y.insn.lsu_len = '0;
         y.insn.lsu_zext = 1'b0;
         y.jal_result = '0;
      end
      if (!pk) begin
         y.predicted_flag = 1'b0;
         y.mispredict_target = '0;
      end
      return y;
   endfunction

   task automatic report(input string msg);
      $display("ERROR at %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic print_counts();
      $display("checks %0d, errors %0d", checks, errors);
   endtask

   task automatic drive_random(input bit allow_padv);
      dec_insn_t    d;
      ctrl_hazard_t c;
      logic [127:0] raw;
      logic [31:0]  r;
      raw = {next_rand(), next_rand(), next_rand(), next_rand()};
      d = raw[$bits(dec_insn_t)-1:0];
      r = next_rand();
      d.opc = opc_e'(4'(r % 15));
      d.rfa = pick_reg();
      d.rfb = pick_reg();
      d.rfd = pick_reg();
      c.rfd = pick_reg();
      r = next_rand();
      c.is_load = (r[1:0] == 2'b00);
      c.is_mfspr = (r[3:2] == 2'b00);
      c.is_mul = (r[5:4] == 2'b00);
      dec_i <= d;
      ctrl_i <= c;
      decode_rfb_i <= next_rand();
      execute_rfb_i <= next_rand();
      predicted_flag_i <= r[6];
      padv_i <= allow_padv && ((r[31:16] % 10) < 7);
      pipeline_flush_i <= (r[26:22] == 5'd0);
   endtask

   // expected outputs this cycle and execute state after the next edge
   task automatic predict();
      logic           pipe;
      logic           ctrl_il;
      logic           hit_ab;
      logic           exe_late;
      logic           jr_op;
      logic           jr_stall;
      logic           take_imm;
      logic           is_cond;
      logic [OFF_W-1:0] off_raw;
      logic [OPW-1:0] imm_t;
      logic [OPW-1:0] reg_t;
      pipe = (`DX_MUL_PIPELINED != 0);
      ctrl_il = (ctrl_i.is_load || ctrl_i.is_mfspr || (ctrl_i.is_mul && pipe)) &&
                (ctrl_i.rfd == dec_i.rfa || ctrl_i.rfd == dec_i.rfb);
      hit_ab = (m_exe.insn.rfd == dec_i.rfa) || (m_exe.insn.rfd == dec_i.rfb);
      exe_late = (m_exe.insn.opc inside {OPC_LOAD, OPC_MFSPR}) ||
                 (m_exe.insn.opc == OPC_MUL && pipe);
      jr_op = dec_i.opc inside {OPC_JR, OPC_JALR};
      jr_stall = jr_op && (ctrl_il || (m_exe.insn.rf_wb && m_exe.insn.rfd == dec_i.rfb));
      exp_bubble = padv_i && ((exe_late && hit_ab) ||
                   (pipe && dec_i.opc == OPC_MUL && (ctrl_il || (m_exe.insn.rf_wb && hit_ab))) ||
                   jr_stall || m_exe.insn.opc == OPC_ATOMIC_STORE || dec_i.opc == OPC_RFE);
      take_imm = (dec_i.opc inside {OPC_J, OPC_JAL}) ||
                 (dec_i.opc == OPC_BF && predicted_flag_i) ||
                 (dec_i.opc == OPC_BNF && !predicted_flag_i);
      // two's complement offset, widened by subtraction
      off_raw = {dec_i.immjbr_upper, dec_i.imm16, 2'b00};
      imm_t = dec_i.pc + OPW'(off_raw);
      if (off_raw[OFF_W-1]) begin
         imm_t = imm_t - (OPW'(1) << OFF_W);
      end
      reg_t = (m_bub || (m_exe.insn.opc inside {OPC_JR, OPC_JALR})) ? execute_rfb_i
                                                                     : decode_rfb_i;
      exp_branch = (take_imm || (jr_op && !jr_stall)) && !pipeline_flush_i;
      exp_target = take_imm ? imm_t : reg_t;
      check_target = take_imm || jr_op;
      exp_align = exp_branch && (exp_target[1:0] != 2'b00);
      exp_next_pc = dec_i.pc + ((`DX_DELAY_SLOT != 0) ? OPW'(8) : OPW'(4));
      exp_mispredict = ((dec_i.opc == OPC_BF && !predicted_flag_i) ||
                        (dec_i.opc == OPC_BNF && predicted_flag_i)) ? imm_t : exp_next_pc;

      is_cond = dec_i.opc inside {OPC_BF, OPC_BNF};
      nxt_exe = m_exe;
      nxt_bub = m_bub;
      nxt_valid = padv_i;
      nxt_data_known = data_known || padv_i;
      nxt_pred_known = pred_known || (padv_i && is_cond);
      if (padv_i) begin
         nxt_exe.insn = dec_i;
         nxt_exe.except_align = exp_align;
         nxt_exe.jal_result = exp_next_pc;
         if (is_cond) begin
            nxt_exe.predicted_flag = predicted_flag_i;
            nxt_exe.mispredict_target = exp_mispredict;
         end
      end
      if (pipeline_flush_i) begin
         nxt_exe = make_inert(nxt_exe, OPC_NOP);
         nxt_bub = 1'b0;
      end else if (padv_i) begin
         nxt_bub = exp_bubble;
         if (exp_bubble) begin
            nxt_exe = make_inert(nxt_exe, (dec_i.opc == OPC_RFE) ? OPC_RFE : OPC_NOP);
         end
      end
   endtask

   task automatic check_outputs();
      exe_insn_t got;
      exe_insn_t want;
      checks++;
      if (decode_bubble_o !== exp_bubble) begin
         report($sformatf("decode_bubble_o is %b, expected %b", decode_bubble_o, exp_bubble));
      end
      if (decode_branch_o !== exp_branch) begin
         report($sformatf("decode_branch_o is %b, expected %b", decode_branch_o, exp_branch));
      end
      if (check_target && decode_branch_target_o !== exp_target) begin
         report($sformatf("branch target is %h, expected %h",
                          decode_branch_target_o, exp_target));
      end
      if (execute_bubble_o !== m_bub) begin
         report($sformatf("execute_bubble_o is %b, expected %b", execute_bubble_o, m_bub));
      end
      if (decode_valid_o !== m_valid) begin
         report($sformatf("decode_valid_o is %b, expected %b", decode_valid_o, m_valid));
      end
      got = mask_unknown(exe_o, data_known, pred_known);
      want = mask_unknown(m_exe, data_known, pred_known);
      if (got !== want) begin
         report($sformatf("exe_o is %h, expected %h", got, want));
      end
   endtask

   task automatic check_reset_values();
      if (exe_o.insn.opc !== OPC_NOP || exe_o.insn.rf_wb !== 1'b0 ||
          exe_o.insn.adder_sub !== 1'b0 || exe_o.insn.adder_carry !== 1'b0 ||
          exe_o.except_align !== 1'b0 || execute_bubble_o !== 1'b0 ||
          decode_valid_o !== 1'b0) begin
         report("control outputs not at their reset values");
      end
   endtask

   initial begin : watchdog
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      print_counts();
      $display("Regression failed");
      $finish;
   end

   initial begin
      rng_state = 32'd36;
      errors = 0;
      checks = 0;
      rst = 1'b1;
      dec_i = '0;
      ctrl_i = '0;
      decode_rfb_i = '0;
      execute_rfb_i = '0;
      predicted_flag_i = 1'b0;
      padv_i = 1'b0;
      pipeline_flush_i = 1'b0;
      nxt_exe = '0;
      nxt_bub = 1'b0;
      nxt_valid = 1'b0;
      nxt_data_known = 1'b0;
      nxt_pred_known = 1'b0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < NUM_CYCLES; i++) begin
         @(posedge clk);
         m_exe = nxt_exe;
         m_bub = nxt_bub;
         m_valid = nxt_valid;
         data_known = nxt_data_known;
         pred_known = nxt_pred_known;
         // no advance in the first cycles so the reset state is visible
         drive_random(i >= 2);
         @(negedge clk);
         if (i < 2) begin
            check_reset_values();
         end
         predict();
         check_outputs();
      end
      print_counts();
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// File: decode_execute.f
+incdir+hdl
hdl/dx_pkg.sv
hdl/dx_hazard.sv
hdl/dx_branch.sv
hdl/dx_stage_reg.sv
hdl/decode_execute.sv
sim/tb_decode_execute.sv

// File: Makefile
# Verilator build and regression run for the decode to execute stage

BIN := obj_dir/Vtb_decode_execute

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): decode_execute.f $(wildcard hdl/*.sv hdl/*.svh sim/*.sv)
	verilator --binary --assert -f decode_execute.f --top-module tb_decode_execute \
		-Mdir obj_dir -o Vtb_decode_execute

# the log decides pass or fail
run: $(BIN)
	$(BIN) | tee sim.log
	grep -qx "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
